//--- compile.f
design/videoPkg.sv
design/gamePkg.sv
design/vgaTiming.sv
design/spriteRegs.sv
design/background.sv
design/frogSprite.sv
design/pixelOutput.sv
design/gameVideo.sv
verif/clockGen.sv
verif/gameVideoTb.sv

//--- run.sh
#!/bin/sh
# Builds the game video testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module gameVideoTb -f compile.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && exit 0 \
    || { echo "Pass message not found in sim.log"; exit 1; }

//--- verif/gameVideoTb.sv
// Self-checking testbench for the game video top with random Wishbone traffic and a pixel model
`timescale 1ns/10ps
`default_nettype none

module gameVideoTb
    import videoPkg::*;
    import gamePkg::*;
();

    localparam longint FRAME_NS = 800 * 525 * 20;

    logic   clk;
    logic   reset;
    logic   wbCyc;
    logic   wbStb;
    logic   wbWe;
    wbAdrT  wbAdr;
    wbDataT wbDatW;
    wbDataT wbDatR;
    logic   wbAck;
    colorT  color;
    logic   hsync;
    logic   vsync;

    logic [31:0] seed = 32'h48a8;
    int     syncErrors = 0;
    int     colorErrors = 0;
    int     busErrors = 0;
    int     coverageErrors = 0;
    int     visiblePixels = 0;      // Opaque frog pixels inside the active area
    int     clippedPixels = 0;

    // Model of the scan point whose output shows after the current edge
    int     modelCol = 0;
    int     modelRow = 0;
    int     frameIdx = 0;
    int     expCol = -1;
    int     expRow = -1;
    logic   outStarted = 1'b0;
    logic   prevReq = 1'b0;
    videoT  expVideo;
    frogT   modelFrog = '0;
    colPosT regX = '0;
    rowPosT regY = '0;
    logic   regEn = 1'b0;

    clockGen clockGen_i (.clk (clk), .reset (reset));

    gameVideo gameVideo_i (
        .clk    (clk),
        .reset  (reset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .color  (color),
        .hsync  (hsync),
        .vsync  (vsync)
    );

    function automatic logic [31:0] nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 16;          // Upper bits of an LCG are the better ones
    endfunction

    ////////////////////////////////////////
    // Reference painter, sprite and merge rules
    function automatic colorT paintBackground(input int col, input int row);
        int tx;
        int ty;
        int pat;
        tx  = col / 4;
        ty  = row / 4;
        pat = (((tx >> 2) ^ (ty >> 1)) & 1) |
              ((((tx >> 1) ^ (ty >> 2)) & 1) << 1) |
              (((tx ^ ty) & 1) << 2);
        if (col < int'(X_OFFSET_LEFT) || col > int'(X_OFFSET_RIGHT))
            return BLACK;
        if (row <= 32) begin        // Goal strip takes row 32 from the river
            case (pat)
                0, 5, 6: return ENDAREA0;
                1:       return ENDAREA1;
                2:       return ENDAREA2;
                3, 7:    return ENDAREA3;
                default: return ENDAREA4;
            endcase
        end
        if (row <= 224)
            return BLUE1;
        if (row <= 256 || (row >= 448 && row <= 480)) begin
            case (pat)
                1, 3:    return RED1;
                2, 5:    return RED0;
                default: return BLACK;
            endcase
        end
        return BLACK;
    endfunction

    function automatic logic frogOpaque(input int col, input int row, input frogT f);
        int lx;
        int ly;
        int size;
        int corner;
        size   = int'(FROG_SIZE);
        corner = int'(FROG_CORNER);
        lx     = col - int'(f.x);
        ly     = row - int'(f.y);
        if (lx < 0 || lx >= size || ly < 0 || ly >= size)
            return 1'b0;
        return !((lx < corner || lx >= size - corner) && (ly < corner || ly >= size - corner));
    endfunction

    function automatic colorT frogPixelColor(input int col, input int row, input frogT f);
        int lx;
        int ly;
        lx = col - int'(f.x);
        ly = row - int'(f.y);
        if (ly >= 4 && ly <= 7 && ((lx >= 4 && lx <= 7) || (lx >= 24 && lx <= 27)))
            return FROG_EYE;
        return FROG_GREEN;
    endfunction

    function automatic videoT predictPixel(input int col, input int row, input frogT f);
        videoT v;
        v.hsync = !(col >= 656 && col <= 751);
        v.vsync = !(row >= 490 && row <= 491);
        if (col >= 640 || row >= 480)
            v.color = BLACK;
        else if (f.enable && frogOpaque(col, row, f))
            v.color = frogPixelColor(col, row, f);
        else
            v.color = paintBackground(col, row);
        return v;
    endfunction

    function automatic wbDataT expectedRead(input wbAdrT adr);
        case (adr)
            ADDR_FROG_X: return {6'd0, regX};
            ADDR_FROG_Y: return {6'd0, regY};
            ADDR_CTRL:   return {15'd0, regEn};
            default:     return '0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Wishbone master
    task automatic busAccess(input logic we, input wbAdrT adr, input wbDataT dat,
                             output wbDataT rdData);
        int cycles;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr;
        wbDatW <= dat;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wbAck && cycles < 8);
        assert (wbAck) else begin
            busErrors++;
            $display("Wishbone slave gave no ack within 8 cycles at %0d ns", $time);
        end
        assert (!wbAck || cycles == 2) else begin
            busErrors++;
            $display("CHECK FAILED at %0d ns: ack %0d cycles after strobe, expected 1",
                     $time, cycles - 1);
        end
        rdData = wbDatR;
        if (we) begin       // Host copy changed on the ack edge
            case (adr)
                ADDR_FROG_X: regX = dat[9:0];
                ADDR_FROG_Y: regY = dat[9:0];
                ADDR_CTRL:   regEn = dat[0];
                default: ;
            endcase
        end
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
        @(negedge clk);
        assert (wbAck === 1'b0) else begin
            busErrors++;
            $display("CHECK FAILED at %0d ns: wbAck lasted more than one cycle", $time);
        end
    endtask

    task automatic checkRead(input wbAdrT adr);
        wbDataT rd;
        busAccess(1'b0, adr, wbDataT'(nextRandom()), rd);
        assert (rd === expectedRead(adr)) else begin
            busErrors++;
            $display("CHECK FAILED at %0d ns: read of address %0d gave %h, expected %h",
                     $time, adr, rd, expectedRead(adr));
        end
    endtask

    task automatic runBusTraffic(input int count);
        logic [31:0] r;
        wbDataT      rd;
        for (int i = 0; i < count; i++) begin
            r = nextRandom();
            repeat (r[4:2]) @(posedge clk);     // Idle gap
            if (r[0])
                busAccess(1'b1, wbAdrT'(r[6:5]), wbDataT'(nextRandom()), rd);
            checkRead(wbAdrT'(r[6:5]));
        end
        checkRead(2'd3);
    endtask

    task automatic placeFrog(input int frame);
        colPosT      x;
        rowPosT      y;
        logic [31:0] junk;
        wbDataT      rd;
        if (frame == 0) begin
            x = colPosT'(616 + nextRandom() % 24);  // Box crosses the right and bottom edges
            y = rowPosT'(456 + nextRandom() % 24);
        end else begin
            x = colPosT'(nextRandom() % 609);
            y = rowPosT'(nextRandom() % 449);
        end
        junk = nextRandom();
        busAccess(1'b1, ADDR_FROG_X, {junk[15:10], x}, rd);
        busAccess(1'b1, ADDR_FROG_Y, {junk[9:4], y}, rd);
        // The edge-crossing box of frame 0 is always shown, later ones at random
        busAccess(1'b1, ADDR_CTRL, {junk[15:1], junk[0] | (frame == 0)}, rd);
        checkRead(ADDR_FROG_X);
        checkRead(ADDR_FROG_Y);
    endtask

    ////////////////////////////////////////
    // Reference model and output checks
    always @(posedge clk) begin
        prevReq = wbCyc && wbStb;
        if (reset) begin
            modelCol   = 0;
            modelRow   = 0;
            frameIdx   = 0;
            outStarted = 1'b0;
            modelFrog  = '0;
            expCol     = -1;
            expRow     = -1;
            expVideo   = '{color: BLACK, hsync: 1'b1, vsync: 1'b1};
        end else if (!outStarted) begin
            outStarted = 1'b1;      // Output register still holds its reset value
        end else begin
            expCol   = modelCol;
            expRow   = modelRow;
            expVideo = predictPixel(modelCol, modelRow, modelFrog);
            if (modelFrog.enable && frogOpaque(modelCol, modelRow, modelFrog)) begin
                if (modelCol < 640 && modelRow < 480)
                    visiblePixels++;
                else
                    clippedPixels++;
            end
            if (modelCol == 0 && modelRow == 0)
                modelFrog = '{x: regX, y: regY, enable: regEn};
            if (modelCol == 799) begin
                modelCol = 0;
                if (modelRow == 524) begin
                    modelRow = 0;
                    frameIdx++;
                end else begin
                    modelRow++;
                end
            end else begin
                modelCol++;
            end
        end
    end

    always @(negedge clk) begin
        if (!prevReq) begin
            assert (wbAck === 1'b0) else begin
                busErrors++;
                $display("CHECK FAILED at %0d ns: wbAck high with no cycle requested", $time);
            end
        end
        assert (hsync === expVideo.hsync && vsync === expVideo.vsync) else begin
            syncErrors++;
            $display("CHECK FAILED at %0d ns: syncs %b%b at col %0d row %0d, expected %b%b",
                     $time, hsync, vsync, expCol, expRow, expVideo.hsync, expVideo.vsync);
        end
        assert (color === expVideo.color) else begin
            colorErrors++;
            $display("CHECK FAILED at %0d ns: colour %b at col %0d row %0d, expected %b",
                     $time, color, expCol, expRow, expVideo.color);
        end
    end

    initial begin
        wbCyc  <= 1'b0;
        wbStb  <= 1'b0;
        wbWe   <= 1'b0;
        wbAdr  <= '0;
        wbDatW <= '0;
        wait (reset == 1'b0);
        for (int frame = 0; frame < 3; frame++) begin
            wait (frameIdx == frame && modelRow >= 200);    // Mid-frame traffic
            runBusTraffic(12);
            placeFrog(frame);
            wait (frameIdx == frame + 1);
        end
        repeat (2) @(posedge clk);
        assert (visiblePixels > 0 && clippedPixels > 0) else begin
            coverageErrors++;
            $display("Sprite overlay was not exercised: %0d visible and %0d clipped pixels",
                     visiblePixels, clippedPixels);
        end
        $display("Error counts: sync %0d, colour %0d, bus %0d, coverage %0d",
                 syncErrors, colorErrors, busErrors, coverageErrors);
        if (syncErrors + colorErrors + busErrors + coverageErrors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // Three frames are checked, so four frame times is ample
    initial begin
        #(4 * FRAME_NS);
        $display("Watchdog expired before three frames were checked");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/clockGen.sv
// Testbench clock with a 20 ns period and a reset held over the first three rising edges
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // Half of the 20 ns period
    end

    initial begin
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- design/gameVideo.sv
// Top of the game video path, with the Wishbone sprite registers on the host side and VGA out
`timescale 1ns/10ps
`default_nettype none

module gameVideo
    import videoPkg::*;
    import gamePkg::*;
(
    input  wire    clk,
    input  wire    reset,
    input  wire    wbCyc,
    input  wire    wbStb,
    input  wire    wbWe,
    input  wbAdrT  wbAdr,
    input  wbDataT wbDatW,
    output wbDataT wbDatR,
    output logic   wbAck,
    output colorT  color,
    output logic   hsync,
    output logic   vsync
);

    scanT  scan;
    frogT  frog;
    colorT bgColor;
    logic  frogHit;
    colorT frogColor;
    videoT video;

    vgaTiming vgaTiming_i (
        .clk   (clk),
        .reset (reset),
        .scan  (scan)
    );

    spriteRegs spriteRegs_i (
        .clk        (clk),
        .reset      (reset),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbDatW     (wbDatW),
        .wbDatR     (wbDatR),
        .wbAck      (wbAck),
        .frameStart (scan.frameStart),
        .frog       (frog)
    );

    background background_i (
        .scan  (scan),
        .color (bgColor)
    );

    frogSprite frogSprite_i (
        .scan      (scan),
        .frog      (frog),
        .frogHit   (frogHit),
        .frogColor (frogColor)
    );

    pixelOutput pixelOutput_i (
        .clk       (clk),
        .reset     (reset),
        .scan      (scan),
        .bgColor   (bgColor),
        .frogHit   (frogHit),
        .frogColor (frogColor),
        .video     (video)
    );

    assign color = video.color;
    assign hsync = video.hsync;
    assign vsync = video.vsync;

endmodule

`default_nettype wire

//--- design/pixelOutput.sv
// Output stage that merges sprite over background, blanks and registers colour with the syncs
`timescale 1ns/10ps
`default_nettype none

module pixelOutput
    import videoPkg::*;
    import gamePkg::*;
(
    input  wire   clk,
    input  wire   reset,
    input  scanT  scan,
    input  colorT bgColor,
    input  wire   frogHit,
    input  colorT frogColor,
    output videoT video
);

    colorT pixelColor;

    always_comb begin
        if (!scan.active)
            pixelColor = BLACK;         // Blanking also clips the sprite
        else if (frogHit)
            pixelColor = frogColor;
        else
            pixelColor = bgColor;
    end

    // Colour and syncs share one register so they leave aligned
    always_ff @(posedge clk) begin
        if (reset)
            video <= '{color: BLACK, hsync: 1'b1, vsync: 1'b1};
        else
            video <= '{color: pixelColor, hsync: scan.hsync, vsync: scan.vsync};
    end

endmodule

`default_nettype wire

//--- design/frogSprite.sv
// Frog sprite hit test and colour for the current scan point, with transparent corners
`timescale 1ns/10ps
`default_nettype none

module frogSprite
    import videoPkg::*;
    import gamePkg::*;
(
    input  scanT  scan,
    input  frogT  frog,
    output logic  frogHit,
    output colorT frogColor
);

    colPosT localCol;
    rowPosT localRow;
    logic   inBox;
    logic   edgeCol;
    logic   edgeRow;
    logic   eyeRow;
    logic   eyeCol;

    // No wrap in the differences once the scan is past the corner
    assign localCol = scan.col - frog.x;
    assign localRow = scan.row - frog.y;

    assign inBox = (scan.col >= frog.x) && (localCol < FROG_SIZE) &&
                   (scan.row >= frog.y) && (localRow < FROG_SIZE);

    assign edgeCol = (localCol < FROG_CORNER) || (localCol >= FROG_SIZE - FROG_CORNER);
    assign edgeRow = (localRow < FROG_CORNER) || (localRow >= FROG_SIZE - FROG_CORNER);

    ////////////////////////////////////////
    // Eyes sit one corner-width in from each side
    assign eyeRow = (localRow >= FROG_CORNER) && (localRow < 2 * FROG_CORNER);
    assign eyeCol = ((localCol >= FROG_CORNER) && (localCol < 2 * FROG_CORNER)) ||
                    ((localCol >= FROG_SIZE - 2 * FROG_CORNER) &&
                     (localCol <  FROG_SIZE - FROG_CORNER));

    assign frogHit   = frog.enable && inBox && !(edgeCol && edgeRow);
    assign frogColor = (eyeRow && eyeCol) ? FROG_EYE : FROG_GREEN;

endmodule

`default_nettype wire

//--- design/background.sv
// Combinational playfield painter for the goal, river and grass strips with XOR tile patterns
`timescale 1ns/10ps
`default_nettype none

module background
    import videoPkg::*;
    import gamePkg::*;
(
    input  scanT  scan,
    output colorT color
);

    logic       inBand;
    logic       goal;
    logic       river;
    logic       grass;
    logic [7:0] tileX;      // 4x4 tile coordinates
    logic [7:0] tileY;
    logic [2:0] pattern;

    assign tileX = scan.col[9:2];
    assign tileY = scan.row[9:2];

    // Cheap pseudorandom texture from scrambled tile bits
    assign pattern[0] = tileX[2] ^ tileY[1];
    assign pattern[1] = tileX[1] ^ tileY[2];
    assign pattern[2] = tileX[0] ^ tileY[0];

    assign inBand = (scan.col >= X_OFFSET_LEFT) && (scan.col <= X_OFFSET_RIGHT);

    assign goal  = inBand && (scan.row <= GOAL_BOTTOM);
    assign river = inBand && (scan.row >= RIVER_TOP) && (scan.row <= RIVER_BOTTOM);
    assign grass = inBand &&
                   (((scan.row >= RIVER_BOTTOM) && (scan.row <= GRASS1_BOTTOM)) ||
                    ((scan.row >= GRASS2_TOP)   && (scan.row <= GRASS2_BOTTOM)));

    always_comb begin
        color = BLACK;
        if (goal) begin     // Checked first, so row 32 belongs to the goal
            case (pattern)
                3'd0:       color = ENDAREA0;
                3'd1:       color = ENDAREA1;
                3'd2:       color = ENDAREA2;
                3'd3:       color = ENDAREA3;
                3'd4:       color = ENDAREA4;
                3'd5, 3'd6: color = ENDAREA0;
                default:    color = ENDAREA3;
            endcase
        end else if (river) begin
            color = BLUE1;
        end else if (grass) begin
            case (pattern)
                3'd1, 3'd3: color = RED1;
                3'd5, 3'd2: color = RED0;
                default:    color = BLACK;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/spriteRegs.sv
// Wishbone classic register block for the frog sprite, with shadow copies taken at frame start
`timescale 1ns/10ps
`default_nettype none

module spriteRegs
    import videoPkg::*;
    import gamePkg::*;
(
    input  wire    clk,
    input  wire    reset,
    input  wire    wbCyc,
    input  wire    wbStb,
    input  wire    wbWe,
    input  wbAdrT  wbAdr,
    input  wbDataT wbDatW,
    output wbDataT wbDatR,
    output logic   wbAck,
    input  wire    frameStart,
    output frogT   frog
);

    colPosT hostX;
    rowPosT hostY;
    logic   hostEnable;
    logic   take;

    // A new access is taken only while no ack is pending
    assign take = wbCyc && wbStb && !wbAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck      <= 1'b0;
            hostX      <= '0;
            hostY      <= '0;
            hostEnable <= 1'b0;
            frog       <= '0;
        end else begin
            wbAck <= take;
            if (take && wbWe) begin
                case (wbAdr)
                    ADDR_FROG_X: hostX      <= wbDatW[9:0];
                    ADDR_FROG_Y: hostY      <= wbDatW[9:0];
                    ADDR_CTRL:   hostEnable <= wbDatW[0];
                    default: ;
                endcase
            end
            if (frameStart)
                frog <= '{x: hostX, y: hostY, enable: hostEnable};   // Screen sees it next frame
        end
    end

    // Master holds the address through the ack cycle
    always_comb begin
        case (wbAdr)
            ADDR_FROG_X: wbDatR = wbDataT'(hostX);
            ADDR_FROG_Y: wbDatR = wbDataT'(hostY);
            ADDR_CTRL:   wbDatR = wbDataT'(hostEnable);
            default:     wbDatR = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/vgaTiming.sv
// Scan generator that walks the 800x525 raster and presents one registered scan point per clock
`timescale 1ns/10ps
`default_nettype none

module vgaTiming
    import videoPkg::*;
(
    input  wire  clk,
    input  wire  reset,
    output scanT scan
);

    colPosT colCnt;     // Position presented on the next clock
    rowPosT rowCnt;
    logic   lastCol;
    logic   lastRow;
    logic   inHSync;
    logic   inVSync;

    assign lastCol = (colCnt == H_TOTAL - colPosT'(1));
    assign lastRow = (rowCnt == V_TOTAL - rowPosT'(1));

    assign inHSync = (colCnt >= H_ACTIVE + H_FRONT) &&
                     (colCnt <  H_ACTIVE + H_FRONT + H_SYNC);
    assign inVSync = (rowCnt >= V_ACTIVE + V_FRONT) &&
                     (rowCnt <  V_ACTIVE + V_FRONT + V_SYNC);

    always_ff @(posedge clk) begin
        if (reset) begin
            colCnt <= '0;
            rowCnt <= '0;
            scan   <= '{col: '0, row: '0, active: 1'b0,
                        hsync: 1'b1, vsync: 1'b1, frameStart: 1'b0};
        end else begin
            scan.col        <= colCnt;
            scan.row        <= rowCnt;
            scan.active     <= (colCnt < H_ACTIVE) && (rowCnt < V_ACTIVE);
            scan.hsync      <= !inHSync;
            scan.vsync      <= !inVSync;
            scan.frameStart <= (colCnt == '0) && (rowCnt == '0);

            if (lastCol) begin
                colCnt <= '0;
                rowCnt <= lastRow ? '0 : rowCnt + 1'b1;   // Row steps at the end of each line
            end else begin
                colCnt <= colCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/gamePkg.sv
// Playfield layout, palette and sprite register map, imported by the game-specific blocks
`default_nettype none

package gamePkg;

    import videoPkg::*;

    ////////////////////////////////////////
    // Playfield layout in pixels
    localparam colPosT X_OFFSET_LEFT  = 10'd96;
    localparam colPosT X_OFFSET_RIGHT = 10'd544;
    localparam colPosT BLOCKSIZE      = 10'd32;
    localparam colPosT FROG_SIZE      = 10'd32;
    localparam colPosT FROG_CORNER    = 10'd4;

    // Strip boundaries, all inclusive
    localparam rowPosT GOAL_BOTTOM   = rowPosT'(1 * BLOCKSIZE);
    localparam rowPosT RIVER_TOP     = rowPosT'(1 * BLOCKSIZE);
    localparam rowPosT RIVER_BOTTOM  = rowPosT'(7 * BLOCKSIZE);
    localparam rowPosT GRASS1_BOTTOM = rowPosT'(8 * BLOCKSIZE);
    localparam rowPosT GRASS2_TOP    = rowPosT'(14 * BLOCKSIZE);
    localparam rowPosT GRASS2_BOTTOM = rowPosT'(15 * BLOCKSIZE);

    ////////////////////////////////////////
    // Palette
    localparam colorT BLACK      = 6'b000000;
    localparam colorT BLUE1      = 6'b000011;
    localparam colorT RED0       = 6'b010000;
    localparam colorT RED1       = 6'b010001;
    localparam colorT ENDAREA0   = 6'b001000;
    localparam colorT ENDAREA1   = 6'b001001;
    localparam colorT ENDAREA2   = 6'b011000;
    localparam colorT ENDAREA3   = 6'b110001;
    localparam colorT ENDAREA4   = 6'b011110;
    localparam colorT FROG_GREEN = 6'b001100;
    localparam colorT FROG_EYE   = 6'b111111;

    ////////////////////////////////////////
    // Sprite register map
    typedef logic [1:0]  wbAdrT;
    typedef logic [15:0] wbDataT;

    localparam wbAdrT ADDR_FROG_X = 2'd0;
    localparam wbAdrT ADDR_FROG_Y = 2'd1;
    localparam wbAdrT ADDR_CTRL   = 2'd2;

    typedef struct packed {
        colPosT x;      // Top-left corner of the sprite box
        rowPosT y;
        logic   enable;
    } frogT;

endpackage

`default_nettype wire

//--- design/videoPkg.sv
// Display timing, coordinate and colour types shared by every block of the video path
`default_nettype none

package videoPkg;

    typedef logic [9:0] colPosT;    // Column count, one step per pixel clock
    typedef logic [9:0] rowPosT;
    typedef logic [5:0] colorT;     // Two bits each of red, green and blue

    ////////////////////////////////////////
    // 640x480 timing in pixel clocks and lines
    localparam colPosT H_ACTIVE = 10'd640;
    localparam colPosT H_FRONT  = 10'd16;
    localparam colPosT H_SYNC   = 10'd96;
    localparam colPosT H_TOTAL  = 10'd800;

    localparam rowPosT V_ACTIVE = 10'd480;
    localparam rowPosT V_FRONT  = 10'd10;
    localparam rowPosT V_SYNC   = 10'd2;
    localparam rowPosT V_TOTAL  = 10'd525;

    typedef struct packed {
        colPosT col;
        rowPosT row;
        logic   active;
        logic   hsync;      // Active low
        logic   vsync;      // Active low
        logic   frameStart;
    } scanT;

    typedef struct packed {
        colorT color;
        logic  hsync;
        logic  vsync;
    } videoT;

endpackage

`default_nettype wire
